// ==== Makefile ====
# Verilator build and run of the decode-to-issue buffer testbench.

VERILATOR ?= verilator
TOP       ?= decode_issue_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only when the pass line shows up in the output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== source/decode_issue_top.sv ====
`timescale 1ns/1ps

module decode_issue_top #(
    parameter int DEPTH = decode_pkg::DEFAULT_DEPTH
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic [1:0]              enqueue_en,
    input  decode_pkg::dec_entry_t  enqueue_data1,
    input  decode_pkg::dec_entry_t  enqueue_data2,
    output logic [1:0]              issue_en,
    output decode_pkg::dec_entry_t  issue_data1,
    output decode_pkg::dec_entry_t  issue_data2,
    output logic                    full,
    output logic                    empty,
    output logic                    fetch_ready
);

    import decode_pkg::*;

    localparam int CNT_W = $clog2(DEPTH + 1);

    dec_entry_t       head_entry1;
    dec_entry_t       head_entry2;
    logic [CNT_W-1:0] count;
    logic [1:0]       dequeue_en;  // Retire strobe back from the selector.

    decode_queue #(.DEPTH(DEPTH)) u_queue (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .enqueue_en    (enqueue_en),
        .enqueue_data1 (enqueue_data1),
        .enqueue_data2 (enqueue_data2),
        .dequeue_en    (dequeue_en),
        .head_entry1   (head_entry1),
        .head_entry2   (head_entry2),
        .count         (count),
        .full          (full),
        .empty         (empty),
        .fetch_ready   (fetch_ready)
    );

    issue_select #(.DEPTH(DEPTH)) u_select (
        .head_entry1 (head_entry1),
        .head_entry2 (head_entry2),
        .count       (count),
        .flush       (flush),
        .dequeue_en  (dequeue_en),
        .issue_en    (issue_en),
        .issue_data1 (issue_data1),
        .issue_data2 (issue_data2)
    );

endmodule

// ==== source/decode_pkg.sv ====
package decode_pkg;

    // Field widths of a decoded entry.
    localparam int REG_IDX_W = 5;   // Architectural register index.
    localparam int TAG_W     = 16;  // Stands in for opcode and immediate.

    // Bit positions inside an entry. The valid bit sits at bit 0.
    localparam int ENTRY_VALID_BIT = 0;
    localparam int ENTRY_WEN_BIT   = 1;
    localparam int ENTRY_RS2_LSB   = 2;
    localparam int ENTRY_RS1_LSB   = ENTRY_RS2_LSB + REG_IDX_W;
    localparam int ENTRY_RD_LSB    = ENTRY_RS1_LSB + REG_IDX_W;
    localparam int ENTRY_TAG_LSB   = ENTRY_RD_LSB + REG_IDX_W;
    localparam int ENTRY_W         = ENTRY_TAG_LSB + TAG_W;  // Tag sits on top.

    // Queue slots by default. Must be a power of two and at least 4.
    localparam int DEFAULT_DEPTH = 8;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [ENTRY_W-1:0]   dec_entry_t;

    // Field extractors, shared by the selector and the checks.
    function automatic reg_idx_t entry_rd(input dec_entry_t e);
        return e[ENTRY_RD_LSB +: REG_IDX_W];
    endfunction

    function automatic reg_idx_t entry_rs1(input dec_entry_t e);
        return e[ENTRY_RS1_LSB +: REG_IDX_W];
    endfunction

    function automatic reg_idx_t entry_rs2(input dec_entry_t e);
        return e[ENTRY_RS2_LSB +: REG_IDX_W];
    endfunction

    function automatic tag_t entry_tag(input dec_entry_t e);
        return e[ENTRY_TAG_LSB +: TAG_W];
    endfunction

endpackage

// ==== source/decode_queue.sv ====
`timescale 1ns/1ps

module decode_queue #(
    parameter int DEPTH = decode_pkg::DEFAULT_DEPTH
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    input  logic [1:0]                  enqueue_en,
    input  decode_pkg::dec_entry_t      enqueue_data1,
    input  decode_pkg::dec_entry_t      enqueue_data2,
    input  logic [1:0]                  dequeue_en,
    output decode_pkg::dec_entry_t      head_entry1,
    output decode_pkg::dec_entry_t      head_entry2,
    output logic [$clog2(DEPTH+1)-1:0]  count,
    output logic                        full,
    output logic                        empty,
    output logic                        fetch_ready
);

    import decode_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);      // Slot index; wraps for free.
    localparam int CNT_W = $clog2(DEPTH + 1);  // Must reach DEPTH itself.

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    dec_entry_t ram [DEPTH];  // Entry storage, written in pairs.

    ptr_t head;        // Oldest occupied slot.
    ptr_t tail;        // Next free slot.
    ptr_t head_plus;
    ptr_t tail_plus;
    cnt_t free_slots;
    cnt_t deq_cnt;     // Entries retired at this edge.
    logic do_enq;      // Pair accepted at this edge.
    logic deq_one;
    logic deq_two;

    // Second slot of each pair, modulo DEPTH.
    assign head_plus = head + ptr_t'(1);
    assign tail_plus = tail + ptr_t'(1);

    always_comb begin
        // Only a full pair strobe counts; a lone bit is ignored.
        do_enq  = (enqueue_en == 2'b11) && !full && !flush;
        deq_one = dequeue_en[0] && !flush;
        deq_two = (dequeue_en == 2'b11) && !flush;  // Head+1 only together with head.
        if (deq_two) begin
            deq_cnt = cnt_t'(2);
        end else if (deq_one) begin
            deq_cnt = cnt_t'(1);
        end else begin
            deq_cnt = '0;
        end
    end

    // Pointers and occupancy.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // Redirect: everything in flight is discarded.
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_enq) begin
                tail <= tail + ptr_t'(2);
            end
            head  <= head + ptr_t'(deq_cnt);
            // Enqueue and dequeue may land on the same edge.
            count <= count + (do_enq ? cnt_t'(2) : cnt_t'(0)) - deq_cnt;
        end
    end

    // Entry storage. Retired slots lose their valid bit.
    always_ff @(posedge clk) begin
        if (flush) begin
            for (int i = 0; i < DEPTH; i++) begin
                ram[i][ENTRY_VALID_BIT] <= 1'b0;
            end
        end else begin
            if (deq_one) begin
                ram[head][ENTRY_VALID_BIT] <= 1'b0;
            end
            if (deq_two) begin
                ram[head_plus][ENTRY_VALID_BIT] <= 1'b0;
            end
            // Tail slots are free whenever the pair is accepted, so no clash with head.
            if (do_enq) begin
                ram[tail]      <= enqueue_data1;  // Older entry first.
                ram[tail_plus] <= enqueue_data2;
            end
        end
    end

    assign head_entry1 = ram[head];
    assign head_entry2 = ram[head_plus];

    // Status flags, all from the registered count.
    assign free_slots  = cnt_t'(DEPTH) - count;
    assign empty       = (count == '0);
    assign full        = (free_slots < cnt_t'(2));   // No room for another pair.
    assign fetch_ready = (free_slots >= cnt_t'(4));  // Room for two more pairs.

endmodule

// ==== source/issue_select.sv ====
`timescale 1ns/1ps

module issue_select #(
    parameter int DEPTH = decode_pkg::DEFAULT_DEPTH
) (
    input  decode_pkg::dec_entry_t      head_entry1,
    input  decode_pkg::dec_entry_t      head_entry2,
    input  logic [$clog2(DEPTH+1)-1:0]  count,
    input  logic                        flush,
    output logic [1:0]                  dequeue_en,
    output logic [1:0]                  issue_en,
    output decode_pkg::dec_entry_t      issue_data1,
    output decode_pkg::dec_entry_t      issue_data2
);

    import decode_pkg::*;

    localparam int CNT_W = $clog2(DEPTH + 1);

    reg_idx_t first_rd;
    logic     first_writes;  // Head entry produces a real register result.
    logic     raw_hazard;    // Second entry reads what the first writes.
    logic     slot1;
    logic     slot2;

    assign first_rd = entry_rd(head_entry1);

    // Register x0 is never a real destination.
    assign first_writes = head_entry1[ENTRY_WEN_BIT] && (first_rd != '0);

    assign raw_hazard = first_writes &&
                        ((first_rd == entry_rs1(head_entry2)) ||
                         (first_rd == entry_rs2(head_entry2)));

    always_comb begin
        // An invalid head blocks itself and everything behind it.
        slot1 = !flush &&
                (count >= CNT_W'(1)) &&
                head_entry1[ENTRY_VALID_BIT];
        // Second issue needs the first, a real entry behind it, and no hazard.
        slot2 = slot1 &&
                (count >= CNT_W'(2)) &&
                head_entry2[ENTRY_VALID_BIT] &&
                !raw_hazard;
    end

    // Issue and retire are the same event; no back-pressure downstream.
    assign issue_en   = {slot2, slot1};
    assign dequeue_en = {slot2, slot1};

    assign issue_data1 = head_entry1;
    assign issue_data2 = head_entry2;

endmodule

// ==== sources.f ====
source/decode_pkg.sv
source/decode_queue.sv
source/issue_select.sv
source/decode_issue_top.sv
tb/decode_issue_sva.sv
tb/decode_issue_tb.sv

// ==== tb/decode_issue_stim.txt ====
# flush enq | entry 1: tag rd rs1 rs2 wen,valid | entry 2: same | exp issue_en tag1 tag2
# exp full empty fetch_ready | test name. Tags hex, registers decimal, the rest binary.
# After reset.
0 00 0000  0  0  0 00  0000  0  0  0 00  00 0000 0000 0 1 1 reset_idle
# Independent pair.
0 11 0001  1  2  3 11  0002  4  5  6 11  00 0000 0000 0 1 1 pair_enqueue
0 00 0000  0  0  0 00  0000  0  0  0 00  11 0001 0002 0 0 1 pair_issue
0 00 0000  0  0  0 00  0000  0  0  0 00  00 0000 0000 0 1 1 pair_drained
# Read-after-write hazard, then a write to register zero.
0 11 0003  7  1  2 11  0004  8  7  3 11  00 0000 0000 0 1 1 raw_enqueue
0 00 0000  0  0  0 00  0000  0  0  0 00  01 0003 0000 0 0 1 raw_first_only
0 00 0000  0  0  0 00  0000  0  0  0 00  01 0004 0000 0 0 1 raw_second_alone
0 11 0005  0  9 10 11  0006 11  0  0 11  00 0000 0000 0 1 1 rd0_enqueue
# Invalid head entry, enqueued while the rd0 pair issues.
0 11 0007 12 13 14 10  0008 15 16 17 11  11 0005 0006 0 0 1 rd0_issue_enq_invalid
0 00 0000  0  0  0 00  0000  0  0  0 00  00 0000 0000 0 0 1 invalid_blocks
0 00 0000  0  0  0 00  0000  0  0  0 00  00 0000 0000 0 0 1 invalid_still_blocks
1 00 0000  0  0  0 00  0000  0  0  0 00  00 0000 0000 0 0 1 flush_invalid
0 00 0000  0  0  0 00  0000  0  0  0 00  00 0000 0000 0 1 1 flush_empty
# Dependent chain fills the queue, both pointers wrap.
0 11 0011  1  0  0 11  0012  2  1  0 11  00 0000 0000 0 1 1 fill_enq1
0 11 0013  3  2  0 11  0014  4  3  0 11  01 0011 0000 0 0 1 fill_enq2
0 11 0015  5  4  0 11  0016  6  5  0 11  01 0012 0000 0 0 1 fill_enq3
0 11 0017  7  6  0 11  0018  8  7  0 11  01 0013 0000 0 0 1 fill_enq4
0 11 0019  9  8  0 11  001a 10  9  0 11  01 0014 0000 0 0 0 fill_enq5
0 11 001b 11 10  0 11  001c 12 11  0 11  01 0015 0000 0 0 0 fill_enq6
0 00 0000  0  0  0 00  0000  0  0  0 00  01 0016 0000 1 0 0 fill_full
0 00 0000  0  0  0 00  0000  0  0  0 00  01 0017 0000 0 0 0 drain_1
0 00 0000  0  0  0 00  0000  0  0  0 00  01 0018 0000 0 0 0 drain_head_wrap
0 00 0000  0  0  0 00  0000  0  0  0 00  01 0019 0000 0 0 1 drain_3
0 00 0000  0  0  0 00  0000  0  0  0 00  01 001a 0000 0 0 1 drain_4
0 00 0000  0  0  0 00  0000  0  0  0 00  01 001b 0000 0 0 1 drain_5
0 00 0000  0  0  0 00  0000  0  0  0 00  01 001c 0000 0 0 1 drain_last
0 00 0000  0  0  0 00  0000  0  0  0 00  00 0000 0000 0 1 1 fill_drained
# Flush with an enqueue in the same cycle.
0 11 0021 20 21 22 11  0022 23 24 25 11  00 0000 0000 0 1 1 flush_pre_enqueue
1 11 0023 26 27 28 11  0024 29 30 31 11  00 0000 0000 0 0 1 flush_with_enqueue
0 00 0000  0  0  0 00  0000  0  0  0 00  00 0000 0000 0 1 1 flush_empty_after
0 00 0000  0  0  0 00  0000  0  0  0 00  00 0000 0000 0 1 1 flush_dropped_pair
0 11 0025  1  2  3 11  0026  4  5  6 11  00 0000 0000 0 1 1 post_flush_enqueue
0 00 0000  0  0  0 00  0000  0  0  0 00  11 0025 0026 0 0 1 post_flush_issue
0 00 0000  0  0  0 00  0000  0  0  0 00  00 0000 0000 0 1 1 final_idle

// ==== tb/decode_issue_sva.sv ====
`timescale 1ns/1ps

module decode_issue_sva #(
    parameter int DEPTH = decode_pkg::DEFAULT_DEPTH
) (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        flush,
    input logic [1:0]                  enqueue_en,
    input logic [1:0]                  dequeue_en,
    input logic [$clog2(DEPTH+1)-1:0]  count,
    input logic                        full,
    input logic                        empty
);

    // Occupancy stays within the RAM.
    count_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        int'(count) <= DEPTH)
        else $error("Queue count %0d is above DEPTH %0d.", count, DEPTH);

    // Decode only ever sends a whole pair or nothing.
    enqueue_pairs_only: assert property (@(posedge clk) disable iff (!arst_n)
        (enqueue_en == 2'b00) || (enqueue_en == 2'b11))
        else $error("Enqueue strobe %b is not a pair.", enqueue_en);

    dequeue_in_order: assert property (@(posedge clk) disable iff (!arst_n)
        dequeue_en != 2'b10)  // Head+1 never retires without the head.
        else $error("Dequeue strobe retires head+1 without head.");

    // A redirect leaves nothing behind once the edge has passed.
    flush_empties: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> empty)
        else $error("Queue is not empty in the cycle after a flush.");

endmodule

bind decode_queue decode_issue_sva #(.DEPTH(DEPTH)) u_sva (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .enqueue_en (enqueue_en),
    .dequeue_en (dequeue_en),
    .count      (count),
    .full       (full),
    .empty      (empty)
);

// ==== tb/decode_issue_tb.sv ====
`timescale 1ns/1ps

module decode_issue_tb;

    import decode_pkg::*;

    localparam int DEPTH      = DEFAULT_DEPTH;
    localparam int LINE_CHARS = 160;  // Longest stim line in characters.
    localparam int NAME_CHARS = 32;   // Longest test name.
    localparam int FIELDS     = 19;   // Columns on a data line.
    localparam string STIM_FILE = "tb/decode_issue_stim.txt";

    typedef logic [8*LINE_CHARS-1:0] line_t;
    typedef logic [8*NAME_CHARS-1:0] name_t;

    logic       clk;
    logic       arst_n;
    logic       flush;
    logic [1:0] enqueue_en;
    dec_entry_t enqueue_data1;
    dec_entry_t enqueue_data2;
    logic [1:0] issue_en;
    dec_entry_t issue_data1;
    dec_entry_t issue_data2;
    logic       full;
    logic       empty;
    logic       fetch_ready;

    // Fields of the stim line being applied.
    logic       f_flush;
    logic [1:0] f_en;
    tag_t       f_tag1, f_tag2;
    reg_idx_t   f_rd1, f_a1, f_b1;
    reg_idx_t   f_rd2, f_a2, f_b2;
    logic [1:0] f_flags1, f_flags2;  // Write enable, then valid.
    logic [1:0] x_issue;
    tag_t       x_tag1, x_tag2;
    logic       x_full, x_empty, x_ready;
    name_t      f_name;

    line_t stim_lines[$];  // Data lines only, comments dropped.
    int    error_count = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0;
    logic  stim_ok     = 1'b0;

    decode_issue_top #(.DEPTH(DEPTH)) uut (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .enqueue_en    (enqueue_en),
        .enqueue_data1 (enqueue_data1),
        .enqueue_data2 (enqueue_data2),
        .issue_en      (issue_en),
        .issue_data1   (issue_data1),
        .issue_data2   (issue_data2),
        .full          (full),
        .empty         (empty),
        .fetch_ready   (fetch_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

    // Watchdog. The limit follows from the number of stim lines.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    // Splits one text line into the field variables; returns the number matched.
    task automatic parse_line(input line_t text, output int fields);
        fields = $sscanf(text, "%b %b %h %d %d %d %b %h %d %d %d %b %b %h %h %b %b %b %s",
                         f_flush, f_en, f_tag1, f_rd1, f_a1, f_b1, f_flags1,
                         f_tag2, f_rd2, f_a2, f_b2, f_flags2,
                         x_issue, x_tag1, x_tag2, x_full, x_empty, x_ready, f_name);
    endtask

    // Reads the whole stim file up front so the watchdog knows the run length.
    task automatic load_stim();
        int    fd;
        int    fields;
        line_t text;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while ($fgets(text, fd) != 0) begin
                parse_line(text, fields);
                if (fields == FIELDS) begin
                    stim_lines.push_back(text);
                end else if (fields > 0) begin
                    error_count++;
                    $display("Stim line with %0d of %0d fields was skipped.", fields, FIELDS);
                end
            end
            $fclose(fd);
            if (stim_lines.size() == 0) begin
                error_count++;
                $display("The stimulus file holds no data lines.");
            end
            stim_ok     = 1'b1;
            cycle_limit = stim_lines.size() + 20;
        end
    endtask

    // Builds an entry from its fields, tag on top and valid at bit 0.
    function automatic dec_entry_t pack_entry(input tag_t tag, input reg_idx_t rd,
                                              input reg_idx_t rs1, input reg_idx_t rs2,
                                              input logic [1:0] flags);
        dec_entry_t e;
        e = '0;
        e[ENTRY_TAG_LSB +: TAG_W]     = tag;
        e[ENTRY_RD_LSB +: REG_IDX_W]  = rd;
        e[ENTRY_RS1_LSB +: REG_IDX_W] = rs1;
        e[ENTRY_RS2_LSB +: REG_IDX_W] = rs2;
        e[ENTRY_WEN_BIT]              = flags[1];
        e[ENTRY_VALID_BIT]            = flags[0];
        return e;
    endfunction

    task automatic check_value(input name_t test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch in %0s, %0s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_outputs();
        check_value(f_name, "issue_en", 32'(x_issue), 32'(issue_en));
        // Tags only mean something in a slot that issues.
        if (x_issue[0]) begin
            check_value(f_name, "issue tag 1", 32'(x_tag1), 32'(entry_tag(issue_data1)));
        end
        if (x_issue[1]) begin
            check_value(f_name, "issue tag 2", 32'(x_tag2), 32'(entry_tag(issue_data2)));
        end
        check_value(f_name, "full", 32'(x_full), 32'(full));
        check_value(f_name, "empty", 32'(x_empty), 32'(empty));
        check_value(f_name, "fetch_ready", 32'(x_ready), 32'(fetch_ready));
    endtask

    initial begin
        int fields;
        arst_n        = 1'b0;
        flush         = 1'b0;
        enqueue_en    = 2'b00;
        enqueue_data1 = '0;
        enqueue_data2 = '0;
        load_stim();
        if (!stim_ok) begin
            $display("The stimulus file %0s could not be opened.", STIM_FILE);
            $display("sim failed");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            #2 arst_n = 1'b1;
            foreach (stim_lines[i]) begin
                @(posedge clk);
                #2;  // Inputs change well clear of the edge.
                parse_line(stim_lines[i], fields);
                flush         = f_flush;
                enqueue_en    = f_en;
                enqueue_data1 = pack_entry(f_tag1, f_rd1, f_a1, f_b1, f_flags1);
                enqueue_data2 = pack_entry(f_tag2, f_rd2, f_a2, f_b2, f_flags2);
                #16;  // Sample just before the next edge.
                check_outputs();
            end
            $display("Done: %0d stim lines, %0d errors.", stim_lines.size(), error_count);
            if (error_count == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule
